/* vlog.f */
common/elevator_pkg.sv
src/request_latch.sv
dispatch/sweep_select.sv
dispatch/floor_dispatcher.sv
src/floor_logic_top.sv
tb/tb_clock_gen.sv
tb/floor_logic_tb.sv

/* Bender.yml */
package:
  name: floor_logic

sources:
  - common/elevator_pkg.sv
  - src/request_latch.sv
  - dispatch/sweep_select.sv
  - dispatch/floor_dispatcher.sv
  - src/floor_logic_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/floor_logic_tb.sv

/* tb/floor_logic_tb.sv */
// Directed testbench for the floor controller, with a car motion model and a sweep reference model
`timescale 1ns/1ps

module floor_logic_tb;

    import elevator_pkg::*;

    localparam int NUM_FLOORS      = 11;
    localparam int TRIP_CYCLES     = 4 * (NUM_FLOORS - 1) + 12;
    localparam int QUIET_CYCLES    = NUM_FLOORS * TRIP_CYCLES;
    localparam int WATCHDOG_CYCLES = 40 * TRIP_CYCLES + 400;
    localparam logic [31:0] LFSR_SEED = 32'h6c611575;

    logic        clock;
    logic        reset_n;
    buttons_t    buttons;
    car_status_t status;
    service_t    service;
    logic        door_open_button;
    logic        door_close_button;
    floor_mask_t call_lights;
    floor_mask_t panel_lights;
    target_t     target;
    logic        target_valid;
    logic        target_ready;
    logic        door_open_allowed;
    logic        door_close_allowed;

    // Car model state and reference model state
    floor_t      car_floor;
    logic        car_moving;
    logic        car_enable;
    logic        in_flight;
    logic [31:0] car_lfsr;
    logic [31:0] test_lfsr;
    floor_t      accepted_q[$];
    floor_t      expected_q[$];
    floor_t      model_floor;
    dir_t        model_dir;
    int          checks = 0;
    int          errors = 0;
    int          failures = 0;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(2)) clock_i (.clock(clock), .reset_n(reset_n));

    floor_logic_top #(.NUM_FLOORS(NUM_FLOORS)) dut_i (
        .clock(clock), .reset_n(reset_n), .buttons(buttons), .status(status),
        .service(service), .door_open_button(door_open_button),
        .door_close_button(door_close_button), .call_lights(call_lights),
        .panel_lights(panel_lights), .target(target), .target_valid(target_valid),
        .target_ready(target_ready), .door_open_allowed(door_open_allowed),
        .door_close_allowed(door_close_allowed)
    );

    assign status = '{floor: car_floor, moving: car_moving};

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Fibonacci LFSR, taps 32 22 2 1, new bit enters at bit 0
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int count, output floor_mask_t bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            test_lfsr = lfsr_next(test_lfsr);
            bits[i]   = test_lfsr[0];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        assert (actual === expected) else begin
            $display("ERROR %s expected %h actual %h at %0t", name, expected, actual, $time);
            errors++;
        end
    endtask

    task automatic report_counts();
        $display("Checks %0d, value errors %0d, other failures %0d", checks, errors, failures);
    endtask

    // Nearest pending floor strictly ahead, -1 when nothing lies that way
    function automatic int nearest_ahead(floor_mask_t left, int cur, dir_t d);
        int pos;
        for (int step = 1; step < NUM_FLOORS; step++) begin
            pos = (d == DIR_UP) ? cur + step : cur - step;
            if (pos >= 0 && pos < NUM_FLOORS && left[pos]) begin
                return pos;
            end
        end
        return -1;
    endfunction

    // Sweep order for a set of requests, advancing the model to the last stop
    task automatic build_expected(input floor_mask_t mask);
        floor_mask_t left;
        int          cur;
        int          pick;
        dir_t        d;
        expected_q.delete();
        left = mask;
        cur  = model_floor;
        d    = model_dir;
        while (left != '0) begin
            pick = nearest_ahead(left, cur, d);
            if (pick < 0) begin
                d    = (d == DIR_UP) ? DIR_DOWN : DIR_UP;
                pick = nearest_ahead(left, cur, d);
            end
            if (pick < 0) break;
            expected_q.push_back(floor_t'(pick));
            left[pick] = 1'b0;
            cur        = pick;
        end
        model_floor = floor_t'(cur);
        model_dir   = d;
    endtask

    task automatic place_car(input floor_t f);
        @(posedge clock);
        car_floor   <= f;
        car_moving  <= 1'b0;
        model_floor = f;
    endtask

    task automatic press_buttons(input floor_mask_t hall, input floor_mask_t panel);
        @(posedge clock);
        buttons <= '{hall: hall, panel: panel};
        @(posedge clock);
        buttons <= '0;
    endtask

    // Lights out, no offer and the car parked
    task automatic wait_quiet();
        int   cycles;
        logic quiet;
        cycles = 0;
        quiet  = 1'b0;
        while (!quiet && cycles < QUIET_CYCLES) begin
            @(negedge clock);
            cycles++;
            quiet = ((call_lights | panel_lights) == '0) && !target_valid && !in_flight;
        end
        assert (quiet) else begin
            $display("Requests were not all served within %0d cycles", QUIET_CYCLES);
            failures++;
        end
    endtask

    // Lets the car run and compares its targets with the sweep order
    task automatic finish_requests(input floor_mask_t mask);
        build_expected(mask);
        @(posedge clock);
        car_enable <= 1'b1;
        wait_quiet();
        assert (accepted_q.size() == expected_q.size()) else begin
            $display("Car received %0d targets where %0d were expected",
                     accepted_q.size(), expected_q.size());
            failures++;
        end
        for (int i = 0; i < accepted_q.size() && i < expected_q.size(); i++) begin
            check_value("target.floor", accepted_q[i], expected_q[i]);
        end
    endtask

    //////////////////////////////
    // Car model and monitors
    //////////////////////////////

    initial begin : car_model
        int     delay;
        floor_t dest;
        floor_t pos;
        car_floor    = '0;
        car_moving   = 1'b0;
        target_ready = 1'b0;
        in_flight    = 1'b0;
        car_lfsr     = LFSR_SEED;
        forever begin
            @(posedge clock);
            if (reset_n && car_enable && target_valid) begin
                delay = 0;
                repeat (2) begin
                    car_lfsr = lfsr_next(car_lfsr);
                    delay    = (delay << 1) | car_lfsr[0];
                end
                repeat (delay) @(posedge clock);
                target_ready <= 1'b1;
                // Transfer edge
                @(posedge clock);
                target_ready <= 1'b0;
                in_flight    <= 1'b1;
                dest = target.floor;
                accepted_q.push_back(dest);
                pos = car_floor;
                while (pos != dest) begin
                    car_moving <= 1'b1;
                    repeat (4) @(posedge clock);
                    pos = (dest > pos) ? pos + 1'b1 : pos - 1'b1;
                    car_floor <= pos;
                end
                car_moving <= 1'b0;
                in_flight  <= 1'b0;
            end
        end
    end

    // One target in flight at a time
    always @(posedge clock) begin
        if (reset_n && in_flight) begin
            assert (!target_valid) else begin
                $display("A second target was offered before the car arrived");
                failures++;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        report_counts();
        $display("** FAIL **");
        $finish;
    end

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_reset_state();
        @(negedge clock);
        check_value("call_lights", call_lights, '0);
        check_value("panel_lights", panel_lights, '0);
        check_value("target_valid", target_valid, 1'b0);
        check_value("target.direction", target.direction, DIR_UP);
        check_value("door_open_allowed", door_open_allowed, 1'b0);
        check_value("door_close_allowed", door_close_allowed, 1'b0);
    endtask

    task automatic test_press_latching();
        place_car(4'd3);
        car_enable <= 1'b0;
        accepted_q.delete();
        @(posedge clock);
        buttons <= '{hall: floor_bit(4'd6), panel: floor_bit(4'd1)};
        @(negedge clock);
        check_value("call_lights", call_lights, '0);
        @(posedge clock);
        buttons <= '0;
        @(negedge clock);
        check_value("call_lights", call_lights, floor_bit(4'd6));
        check_value("panel_lights", panel_lights, floor_bit(4'd1));
        // Car stands at floor 3
        press_buttons(floor_bit(4'd3), floor_bit(4'd3));
        service <= '{power_on: 1'b1, emergency: 1'b1};
        press_buttons(floor_bit(4'd8), floor_bit(4'd9));
        service <= '{power_on: 1'b0, emergency: 1'b0};
        press_buttons(floor_bit(4'd10), floor_bit(4'd0));
        service <= '{power_on: 1'b1, emergency: 1'b0};
        @(negedge clock);
        check_value("call_lights", call_lights, floor_bit(4'd6));
        check_value("panel_lights", panel_lights, floor_bit(4'd1));
        finish_requests(floor_bit(4'd6) | floor_bit(4'd1));
    endtask

    task automatic test_sweep_order();
        floor_mask_t mask;
        floor_mask_t split;
        place_car(4'd0);
        accepted_q.delete();
        press_buttons('0, floor_bit(4'd4));
        finish_requests(floor_bit(4'd4));
        // At floor 4 heading up
        accepted_q.delete();
        press_buttons(floor_bit(4'd1) | floor_bit(4'd9), floor_bit(4'd6));
        finish_requests(floor_bit(4'd1) | floor_bit(4'd6) | floor_bit(4'd9));
        for (int round = 0; round < 2; round++) begin
            draw_bits(NUM_FLOORS, mask);
            draw_bits(NUM_FLOORS, split);
            mask &= ~floor_bit(model_floor);
            if (mask == '0) begin
                mask = floor_bit((model_floor == 0) ? floor_t'(NUM_FLOORS - 1) : 4'd0);
            end
            accepted_q.delete();
            press_buttons(mask & split, mask & ~split);
            finish_requests(mask);
        end
    endtask

    task automatic test_arrival_clear();
        int cycles;
        place_car(4'd0);
        accepted_q.delete();
        press_buttons(floor_bit(4'd5) | floor_bit(4'd8), floor_bit(4'd5) | floor_bit(4'd9));
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (call_lights[5] && cycles < TRIP_CYCLES);
        assert (!call_lights[5]) else begin
            $display("Car never arrived at floor 5");
            failures++;
        end
        check_value("call_lights", call_lights, floor_bit(4'd8));
        check_value("panel_lights", panel_lights, floor_bit(4'd9));
        finish_requests(floor_bit(4'd5) | floor_bit(4'd8) | floor_bit(4'd9));
    endtask

    task automatic test_back_pressure();
        target_t held;
        int      cycles;
        place_car(4'd0);
        car_enable <= 1'b0;
        accepted_q.delete();
        press_buttons('0, floor_bit(4'd5));
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!target_valid && cycles < 8);
        assert (target_valid) else begin
            $display("No target was offered for the request at floor 5");
            failures++;
        end
        held = target;
        check_value("target", held, target_t'{floor: 4'd5, direction: DIR_UP});
        for (int i = 0; i < 8; i++) begin
            @(posedge clock);
            case (i)
                0: door_close_button <= 1'b1;
                1: buttons <= '{hall: floor_bit(4'd9), panel: '0};
                2: buttons <= '0;
                3: service <= '{power_on: 1'b1, emergency: 1'b1};
                6: service <= '{power_on: 1'b1, emergency: 1'b0};
                default: ;
            endcase
            @(negedge clock);
            check_value("target_valid", target_valid, 1'b1);
            check_value("target", target, held);
            // Close is granted in idle only, the car is stopped and powered here
            check_value("door_close_allowed", door_close_allowed, 1'b0);
        end
        @(posedge clock);
        door_close_button <= 1'b0;
        finish_requests(floor_bit(4'd5) | floor_bit(4'd9));
    endtask

    // Door grants are registered, expected from stop, power and button state
    task automatic door_step(input logic power, input logic moving,
                             input logic open, input logic close);
        @(posedge clock);
        service           <= '{power_on: power, emergency: 1'b0};
        car_moving        <= moving;
        door_open_button  <= open;
        door_close_button <= close;
        @(posedge clock);
        @(negedge clock);
        check_value("door_open_allowed", door_open_allowed, power && !moving && open);
        check_value("door_close_allowed", door_close_allowed,
                    power && !moving && close && !open);
    endtask

    task automatic test_door_permissions();
        place_car(4'd2);
        door_step(1'b1, 1'b0, 1'b1, 1'b0);
        door_step(1'b1, 1'b0, 1'b1, 1'b1);
        door_step(1'b1, 1'b0, 1'b0, 1'b1);
        door_step(1'b0, 1'b0, 1'b1, 1'b0);
        door_step(1'b1, 1'b1, 1'b1, 1'b0);
        door_step(1'b1, 1'b1, 1'b0, 1'b1);
        door_step(1'b1, 1'b0, 1'b0, 1'b0);
    endtask

    initial begin : main
        buttons           = '0;
        service           = '{power_on: 1'b1, emergency: 1'b0};
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        car_enable        = 1'b1;
        test_lfsr         = LFSR_SEED;
        model_floor       = '0;
        model_dir         = DIR_UP;
        do @(posedge clock); while (reset_n !== 1'b1);
        test_reset_state();
        test_press_latching();
        test_sweep_order();
        test_arrival_clear();
        test_back_pressure();
        test_door_permissions();
        report_counts();
        if (errors == 0 && failures == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* tb/tb_clock_gen.sv */
// Testbench clock and reset source, instantiated once by the floor controller testbench
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // Reset released on a rising edge, like every other stimulus
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset_n <= 1'b1;
    end

endmodule

/* src/floor_logic_top.sv */
// Floor-request controller top: request lights feeding the sweep dispatcher, set up per building size
`timescale 1ns/1ps

module floor_logic_top #(
    parameter int NUM_FLOORS = 11
) (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::buttons_t    buttons,
    input  elevator_pkg::car_status_t status,
    input  elevator_pkg::service_t    service,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    output elevator_pkg::floor_mask_t call_lights,
    output elevator_pkg::floor_mask_t panel_lights,
    output elevator_pkg::target_t     target,
    output logic                      target_valid,
    input  logic                      target_ready,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    import elevator_pkg::*;

    // Arrival report from dispatcher back to the lights
    logic   arrive_valid;
    floor_t arrive_floor;

    request_latch #(
        .NUM_FLOORS (NUM_FLOORS)
    ) latch_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .buttons      (buttons),
        .status       (status),
        .service      (service),
        .arrive_valid (arrive_valid),
        .arrive_floor (arrive_floor),
        .call_lights  (call_lights),
        .panel_lights (panel_lights)
    );

    floor_dispatcher #(
        .NUM_FLOORS (NUM_FLOORS)
    ) dispatch_i (
        .clock              (clock),
        .reset_n            (reset_n),
        .call_lights        (call_lights),
        .panel_lights       (panel_lights),
        .status             (status),
        .service            (service),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .target             (target),
        .target_valid       (target_valid),
        .target_ready       (target_ready),
        .arrive_valid       (arrive_valid),
        .arrive_floor       (arrive_floor),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

/* dispatch/floor_dispatcher.sv */
// Dispatcher: issues sweep targets to the car, detects arrival and grants the door buttons
`timescale 1ns/1ps

module floor_dispatcher #(
    parameter int NUM_FLOORS = 11
) (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::floor_mask_t call_lights,
    input  elevator_pkg::floor_mask_t panel_lights,
    input  elevator_pkg::car_status_t status,
    input  elevator_pkg::service_t    service,
    input  logic                      door_open_button,
    input  logic                      door_close_button,
    output elevator_pkg::target_t     target,
    output logic                      target_valid,
    input  logic                      target_ready,
    output logic                      arrive_valid,
    output elevator_pkg::floor_t      arrive_floor,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);

    import elevator_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_OFFER,
        ST_TRAVEL
    } state_t;

    state_t      state;
    dir_t        sweep_dir;
    floor_t      target_floor;
    floor_mask_t pending;
    logic        pending_found;
    floor_t      pending_floor;
    dir_t        pending_dir;
    logic        in_service;
    logic        car_stopped;
    logic        launch;

    //////////////////////////////
    // Next target search
    //////////////////////////////

    assign pending = call_lights | panel_lights;

    sweep_select #(
        .NUM_FLOORS (NUM_FLOORS)
    ) sweep_i (
        .pending        (pending),
        .current_floor  (status.floor),
        .direction      (sweep_dir),
        .found          (pending_found),
        .next_floor     (pending_floor),
        .next_direction (pending_dir)
    );

    assign in_service  = service.power_on && !service.emergency;
    assign car_stopped = !status.moving;

    // New target only from idle, one target in flight at a time
    assign launch = (state == ST_IDLE) && pending_found && in_service;

    //////////////////////////////
    // Dispatch FSM
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state     <= ST_IDLE;
            sweep_dir <= DIR_UP;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (launch) begin
                        state     <= ST_OFFER;
                        sweep_dir <= pending_dir;
                    end
                end
                // Held until the car takes it, even through an emergency
                ST_OFFER: begin
                    if (target_ready) begin
                        state <= ST_TRAVEL;
                    end
                end
                ST_TRAVEL: begin
                    if (arrive_valid) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Floor payload, loaded together with the sweep direction
    always_ff @(posedge clock) begin
        if (launch) begin
            target_floor <= pending_floor;
        end
    end

    assign target       = '{floor: target_floor, direction: sweep_dir};
    assign target_valid = (state == ST_OFFER);

    // Car standing at the dispatched floor ends the trip
    assign arrive_valid = (state == ST_TRAVEL) && car_stopped && (status.floor == target_floor);
    assign arrive_floor = target_floor;

    //////////////////////////////
    // Door permissions
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            door_open_allowed  <= car_stopped && service.power_on && door_open_button;
            // Open button overrides close
            door_close_allowed <= car_stopped && service.power_on && door_close_button &&
                                  !door_open_button && (state == ST_IDLE);
        end
    end

    //////////////////////////////
    // Protocol checks
    //////////////////////////////

    target_held: assert property (
        @(posedge clock) disable iff (!reset_n)
        target_valid && !target_ready |=> target_valid && $stable(target)
    ) else $error("target changed or dropped under back-pressure");

    arrive_single: assert property (
        @(posedge clock) disable iff (!reset_n)
        arrive_valid |=> !arrive_valid
    ) else $error("arrive_valid longer than one cycle");

    target_in_range: assert property (
        @(posedge clock) disable iff (!reset_n)
        target_valid |-> (int'(target.floor) < NUM_FLOORS)
    ) else $error("target floor %0d out of range", target.floor);

endmodule

/* dispatch/sweep_select.sv */
// Sweep search: picks the nearest pending floor ahead of the car and reverses when none is ahead
`timescale 1ns/1ps

module sweep_select #(
    parameter int NUM_FLOORS = 11
) (
    input  elevator_pkg::floor_mask_t pending,
    input  elevator_pkg::floor_t      current_floor,
    input  elevator_pkg::dir_t        direction,
    output logic                      found,
    output elevator_pkg::floor_t      next_floor,
    output elevator_pkg::dir_t        next_direction
);

    import elevator_pkg::*;

    logic   above_found;
    floor_t above_floor;
    logic   below_found;
    floor_t below_floor;

    // Nearest pending floor above, scanned top down so the lowest hit is kept
    always_comb begin
        above_found = 1'b0;
        above_floor = '0;
        for (int f = NUM_FLOORS - 1; f >= 0; f--) begin
            if (pending[f] && (f > int'(current_floor))) begin
                above_found = 1'b1;
                above_floor = floor_t'(f);
            end
        end
    end

    // Nearest pending floor below, scanned bottom up so the highest hit is kept
    always_comb begin
        below_found = 1'b0;
        below_floor = '0;
        for (int f = 0; f < NUM_FLOORS; f++) begin
            if (pending[f] && (f < int'(current_floor))) begin
                below_found = 1'b1;
                below_floor = floor_t'(f);
            end
        end
    end

    // Keep going while something lies ahead, otherwise turn around
    always_comb begin
        found          = above_found || below_found;
        next_floor     = current_floor;
        next_direction = direction;
        if (direction == DIR_UP) begin
            if (above_found) begin
                next_floor     = above_floor;
                next_direction = DIR_UP;
            end else if (below_found) begin
                next_floor     = below_floor;
                next_direction = DIR_DOWN;
            end
        end else begin
            if (below_found) begin
                next_floor     = below_floor;
                next_direction = DIR_DOWN;
            end else if (above_found) begin
                next_floor     = above_floor;
                next_direction = DIR_UP;
            end
        end
    end

endmodule

/* src/request_latch.sv */
// Request lights: latches hall and panel presses per floor and clears a floor's lights on arrival
`timescale 1ns/1ps

module request_latch #(
    parameter int NUM_FLOORS = 11
) (
    input  logic                      clock,
    input  logic                      reset_n,
    input  elevator_pkg::buttons_t    buttons,
    input  elevator_pkg::car_status_t status,
    input  elevator_pkg::service_t    service,
    input  logic                      arrive_valid,
    input  elevator_pkg::floor_t      arrive_floor,
    output elevator_pkg::floor_mask_t call_lights,
    output elevator_pkg::floor_mask_t panel_lights
);

    import elevator_pkg::*;

    // Floors that exist for this building
    localparam floor_mask_t FLOOR_MASK = valid_floors(NUM_FLOORS);

    logic        accept;
    floor_mask_t stop_mask;
    floor_mask_t clear_mask;
    floor_mask_t hall_set;
    floor_mask_t panel_set;
    floor_mask_t call_next;
    floor_mask_t panel_next;

    //////////////////////////////
    // Press qualification
    //////////////////////////////

    // Buttons are dead without power or during an emergency
    assign accept = service.power_on && !service.emergency;

    // A press at the landing where the car stands is answered by the door
    assign stop_mask = status.moving ? '0 : floor_bit(status.floor);

    assign hall_set  = accept ? (buttons.hall & FLOOR_MASK & ~stop_mask) : '0;
    assign panel_set = accept ? (buttons.panel & FLOOR_MASK & ~stop_mask) : '0;

    // Arrival clears both lights of the served floor
    assign clear_mask = arrive_valid ? floor_bit(arrive_floor) : '0;

    //////////////////////////////
    // Light registers
    //////////////////////////////

    // Clear is applied last so arrival wins over a same-cycle press
    assign call_next  = (call_lights | hall_set) & ~clear_mask;
    assign panel_next = (panel_lights | panel_set) & ~clear_mask;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_lights  <= '0;
            panel_lights <= '0;
        end else begin
            call_lights  <= call_next;
            panel_lights <= panel_next;
        end
    end

    // Floors beyond the building never light up
    lights_in_range: assert property (
        @(posedge clock) disable iff (!reset_n)
        ((call_lights | panel_lights) & ~FLOOR_MASK) == '0
    ) else $error("request light set above floor %0d", NUM_FLOORS - 1);

endmodule

/* common/elevator_pkg.sv */
// Floor, mask, direction and grouped-signal types shared by every module of the floor controller
package elevator_pkg;

    //////////////////////////////
    // Sizing
    //////////////////////////////

    // Largest floor count the mask types can carry
    localparam int MAX_FLOORS = 16;

    // Floor index, 0 is the lowest landing
    typedef logic [3:0] floor_t;

    // One bit per floor, bits at and above the floor count stay zero
    typedef logic [MAX_FLOORS-1:0] floor_mask_t;

    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } dir_t;

    //////////////////////////////
    // Grouped signals
    //////////////////////////////

    // Raw button inputs, one bit per floor
    typedef struct packed {
        floor_mask_t hall;
        floor_mask_t panel;
    } buttons_t;

    // Reported by the car motion controller
    typedef struct packed {
        floor_t floor;
        logic   moving;
    } car_status_t;

    typedef struct packed {
        logic power_on;
        logic emergency;
    } service_t;

    // Offered to the car over the valid/ready handshake
    typedef struct packed {
        floor_t floor;
        dir_t   direction;
    } target_t;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // One-hot mask selecting a single floor
    function automatic floor_mask_t floor_bit(floor_t f);
        return floor_mask_t'(1) << f;
    endfunction

    // Ones for every floor that exists in the building
    function automatic floor_mask_t valid_floors(int num_floors);
        floor_mask_t m;
        m = '0;
        for (int i = 0; i < MAX_FLOORS; i++) begin
            if (i < num_floors) begin
                m[i] = 1'b1;
            end
        end
        return m;
    endfunction

endpackage
